/* Makefile */
# Verilator build and run of the debug bridge testbench
# A failing check ends in $fatal, so the run returns a nonzero status

VERILATOR ?= verilator
TOP       ?= tb_dbg_cpu_bridge
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* compile.f */
src/dbg_spr_pkg.sv
src/dbg_port_pkg.sv
src/toggle_sync.sv
src/dbg_tck_capture.sv
src/spr_access_fsm.sv
src/spr_access_timer.sv
src/dbg_cpu_bridge.sv
testbench/spr_target_model.sv
testbench/tb_dbg_cpu_bridge.sv

/* src/dbg_cpu_bridge.sv */
// One access in flight at a time; cpu_req_o crosses unsynchronized and is held stable by rdy_o
`timescale 1ns/1ps
`default_nettype none

module dbg_cpu_bridge (
  input  logic                   tck_i,
  input  logic                   cpu_clk_i,
  input  logic                   rst_i,
  // Debug port, TCK domain
  input  logic                   strobe_i,
  input  logic                   rd_wrn_i,
  input  dbg_spr_pkg::spr_addr_t addr_i,
  input  dbg_spr_pkg::spr_data_t data_i,
  output logic                   rdy_o,
  output dbg_port_pkg::dbg_rsp_t rsp_o,
  // SPR port, CPU domain
  output dbg_spr_pkg::spr_req_t  cpu_req_o,
  output logic                   cpu_stb_o,
  input  logic                   cpu_ack_i,
  input  dbg_spr_pkg::spr_data_t cpu_data_i
);

  // TCK to CPU start event
  logic start_tgl;
  logic start;
  // CPU to TCK completion event
  logic done_tgl;
  logic done;
  // Timer handshake
  logic busy;
  logic expired;

  ////////////////////////////////////////
  // TCK domain
  ////////////////////////////////////////

  dbg_tck_capture capture0 (
    .tck_i       (tck_i),
    .rst_i       (rst_i),
    .strobe_i    (strobe_i),
    .rd_wrn_i    (rd_wrn_i),
    .addr_i      (addr_i),
    .data_i      (data_i),
    .done_i      (done),
    .req_o       (cpu_req_o),
    .start_tgl_o (start_tgl),
    .rdy_o       (rdy_o)
  );

  // Completion back into TCK
  toggle_sync done_sync0 (
    .clk_i   (tck_i),
    .rst_i   (rst_i),
    .tgl_i   (done_tgl),
    .pulse_o (done)
  );

  ////////////////////////////////////////
  // CPU domain
  ////////////////////////////////////////

  // Start request into the CPU clock
  toggle_sync start_sync0 (
    .clk_i   (cpu_clk_i),
    .rst_i   (rst_i),
    .tgl_i   (start_tgl),
    .pulse_o (start)
  );

  spr_access_fsm fsm0 (
    .cpu_clk_i  (cpu_clk_i),
    .rst_i      (rst_i),
    .start_i    (start),
    .cpu_ack_i  (cpu_ack_i),
    .expired_i  (expired),
    .we_i       (cpu_req_o.we),
    .cpu_data_i (cpu_data_i),
    .cpu_stb_o  (cpu_stb_o),
    .busy_o     (busy),
    .done_tgl_o (done_tgl),
    .rsp_o      (rsp_o)
  );

  spr_access_timer timer0 (
    .cpu_clk_i (cpu_clk_i),
    .rst_i     (rst_i),
    .busy_i    (busy),
    .expired_o (expired)
  );

endmodule

`default_nettype wire

/* src/dbg_port_pkg.sv */
// Debug-side response format and synchronizer depth; SYNC_STAGES must be 2 or more
`default_nettype none

package dbg_port_pkg;

  ////////////////////////////////////////
  // Debug port response
  ////////////////////////////////////////

  // Returned to the TCK side, valid while ready is high
  typedef struct packed {
    // Read data, or zero after a timeout
    dbg_spr_pkg::spr_data_t rdata;
    // Set when the CPU never acknowledged
    logic                   err;
  } dbg_rsp_t;

  ////////////////////////////////////////
  // Clock domain crossing
  ////////////////////////////////////////

  // Flops per synchronizer chain, edge-detect flop not counted
  localparam int unsigned SYNC_STAGES = 2;

endpackage

`default_nettype wire

/* src/dbg_spr_pkg.sv */
// SPR bus types for 32-bit word access only; no byte enables and no bursts exist on this bus
`default_nettype none

package dbg_spr_pkg;

  ////////////////////////////////////////
  // SPR bus payload
  ////////////////////////////////////////

  // Full 32-bit SPR address, decoded by the CPU
  typedef logic [31:0] spr_addr_t;

  // Word-wide SPR data in both directions
  typedef logic [31:0] spr_data_t;

  // One complete request as seen by the CPU
  typedef struct packed {
    spr_addr_t addr;
    spr_data_t wdata;
    // High for a write, low for a read
    logic      we;
  } spr_req_t;

  ////////////////////////////////////////
  // Access timer
  ////////////////////////////////////////

  // Strobe cycles without acknowledge before the access is dropped
  localparam int unsigned SPR_TIMEOUT_CYCLES = 16;
  // Counter must hold SPR_TIMEOUT_CYCLES itself
  localparam int unsigned SPR_TMR_W = 5;

endpackage

`default_nettype wire

/* src/dbg_tck_capture.sv */
// TCK side holds one request at a time; req_o is only stable while rdy_o is low
`timescale 1ns/1ps
`default_nettype none

module dbg_tck_capture (
  input  logic                   tck_i,
  input  logic                   rst_i,
  input  logic                   strobe_i,
  input  logic                   rd_wrn_i,
  input  dbg_spr_pkg::spr_addr_t addr_i,
  input  dbg_spr_pkg::spr_data_t data_i,
  input  logic                   done_i,
  output dbg_spr_pkg::spr_req_t  req_o,
  output logic                   start_tgl_o,
  output logic                   rdy_o
);
  import dbg_spr_pkg::*;

  ////////////////////////////////////////
  // Request acceptance
  ////////////////////////////////////////

  // Captured request, read by the CPU domain without resync
  spr_req_t req_q;
  // Start event, flips once per accepted request
  logic     start_tgl_q;
  logic     rdy_q;
  logic     accept;

  // Strobes while not ready are simply dropped
  assign accept = strobe_i & rdy_q;

  // Payload latch
  always_ff @(posedge tck_i) begin
    if (accept) begin
      req_q.addr <= addr_i;
      req_q.we   <= ~rd_wrn_i;
      // Reads leave the old write data in place
      if (!rd_wrn_i) begin
        req_q.wdata <= data_i;
      end
    end
  end

  ////////////////////////////////////////
  // Handshake state
  ////////////////////////////////////////

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      start_tgl_q <= 1'b0;
      rdy_q       <= 1'b1;
    end else begin
      if (accept) begin
        // Hand the request to the CPU clock domain
        start_tgl_q <= ~start_tgl_q;
        rdy_q       <= 1'b0;
      end else if (done_i) begin
        // Response now valid on the debug side
        rdy_q <= 1'b1;
      end
    end
  end

  // Outputs
  assign req_o       = req_q;
  assign start_tgl_o = start_tgl_q;
  assign rdy_o       = rdy_q;

endmodule

`default_nettype wire

/* src/spr_access_fsm.sv */
// Expects start_i only while idle; an acknowledge in the expiry cycle counts as a normal end
`timescale 1ns/1ps
`default_nettype none

module spr_access_fsm (
  input  logic                   cpu_clk_i,
  input  logic                   rst_i,
  input  logic                   start_i,
  input  logic                   cpu_ack_i,
  input  logic                   expired_i,
  input  logic                   we_i,
  input  dbg_spr_pkg::spr_data_t cpu_data_i,
  output logic                   cpu_stb_o,
  output logic                   busy_o,
  output logic                   done_tgl_o,
  output dbg_port_pkg::dbg_rsp_t rsp_o
);
  import dbg_port_pkg::*;

  ////////////////////////////////////////
  // State
  ////////////////////////////////////////

  typedef enum logic {
    ST_IDLE,
    ST_XFER
  } state_t;

  state_t   state_q;
  state_t   state_d;
  // End of access, by acknowledge or by timeout
  logic     finish;
  // Response held for the TCK side
  dbg_rsp_t rsp_q;
  // Completion event back to the TCK domain
  logic     done_tgl_q;

  ////////////////////////////////////////
  // Strobe and next state
  ////////////////////////////////////////

  // Strobe rises in the start cycle itself
  // and holds for the whole transfer
  assign cpu_stb_o = (state_q == ST_XFER) | ((state_q == ST_IDLE) & start_i);

  // Timer runs exactly while the strobe is out
  assign busy_o = cpu_stb_o;

  assign finish = cpu_stb_o & (cpu_ack_i | expired_i);

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        // Single-cycle access never leaves idle
        if (start_i && !finish) begin
          state_d = ST_XFER;
        end
      end
      ST_XFER: begin
        if (finish) begin
          state_d = ST_IDLE;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge cpu_clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  ////////////////////////////////////////
  // Response and completion toggle
  ////////////////////////////////////////

  always_ff @(posedge cpu_clk_i or posedge rst_i) begin
    if (rst_i) begin
      rsp_q      <= '0;
      done_tgl_q <= 1'b0;
    end else if (finish) begin
      done_tgl_q <= ~done_tgl_q;
      if (cpu_ack_i) begin
        // Writes keep the last read data visible
        if (!we_i) begin
          rsp_q.rdata <= cpu_data_i;
        end
        rsp_q.err <= 1'b0;
      end else begin
        // Hung access, no data to report
        rsp_q.rdata <= '0;
        rsp_q.err   <= 1'b1;
      end
    end
  end

  assign rsp_o      = rsp_q;
  assign done_tgl_o = done_tgl_q;

endmodule

`default_nettype wire

/* src/spr_access_timer.sv */
// Fixed timeout of SPR_TIMEOUT_CYCLES strobe cycles; busy_i must drop for a cycle between accesses
`timescale 1ns/1ps
`default_nettype none

module spr_access_timer (
  input  logic cpu_clk_i,
  input  logic rst_i,
  input  logic busy_i,
  output logic expired_o
);
  import dbg_spr_pkg::*;

  // Last cycle of the allowed window when the start cycle counts as the first
  localparam logic [SPR_TMR_W-1:0] LAST_CNT = SPR_TMR_W'(SPR_TIMEOUT_CYCLES - 1);

  // Busy cycles already completed in this access
  logic [SPR_TMR_W-1:0] cnt_q;

  ////////////////////////////////////////
  // Cycle counter
  ////////////////////////////////////////

  always_ff @(posedge cpu_clk_i or posedge rst_i) begin
    if (rst_i) begin
      cnt_q <= '0;
    end else if (!busy_i) begin
      // Idle keeps the count at zero for the next start
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + SPR_TMR_W'(1);
    end
  end

  // High only inside the final allowed strobe cycle
  assign expired_o = busy_i & (cnt_q == LAST_CNT);

endmodule

`default_nettype wire

/* src/toggle_sync.sv */
// Toggle events must be spaced wider than SYNC_STAGES+1 destination cycles or a change is lost
`timescale 1ns/1ps
`default_nettype none

module toggle_sync (
  input  logic clk_i,
  input  logic rst_i,
  input  logic tgl_i,
  output logic pulse_o
);
  import dbg_port_pkg::*;

  // Synchronizer chain, bit 0 samples the foreign toggle
  logic [SYNC_STAGES-1:0] sync_q;
  // Delayed copy of the synchronized level
  logic                   last_q;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      sync_q <= '0;
      last_q <= 1'b0;
    end else begin
      sync_q <= {sync_q[SYNC_STAGES-2:0], tgl_i};
      last_q <= sync_q[SYNC_STAGES-1];
    end
  end

  // One cycle per level change, either direction
  assign pulse_o = sync_q[SYNC_STAGES-1] ^ last_q;

endmodule

`default_nettype wire

/* testbench/spr_target_model.sv */
// Behavioral SPR target with 16 registers decoded from addr[3:0]; an ack delay of 8'hff never acks
`timescale 1ns/1ps
`default_nettype none

module spr_target_model (
  input  logic                   cpu_clk_i,
  input  logic                   rst_i,
  input  dbg_spr_pkg::spr_req_t  req_i,
  input  logic                   stb_i,
  input  logic [7:0]             ack_delay_i,
  output logic                   ack_o,
  output dbg_spr_pkg::spr_data_t data_o,
  output logic [15:0]            access_cnt_o,
  output dbg_spr_pkg::spr_req_t  last_req_o,
  output logic [7:0]             stb_cycles_o
);
  import dbg_spr_pkg::*;

  // Register file, aliased on the low address bits
  spr_data_t  regs_q [16];
  // Strobe cycles already seen in the current access
  logic [7:0] wait_q;

  // Delay 0 acks in the first strobe cycle
  assign ack_o  = stb_i & (ack_delay_i != 8'hff) & (wait_q == ack_delay_i);
  assign data_o = regs_q[req_i.addr[3:0]];

  always_ff @(posedge cpu_clk_i or posedge rst_i) begin
    if (rst_i) begin
      for (int i = 0; i < 16; i++) begin
        regs_q[i] <= 32'hdead_0000 | 32'(i);
      end
      wait_q       <= '0;
      access_cnt_o <= '0;
      last_req_o   <= '0;
      stb_cycles_o <= '0;
    end else if (!stb_i) begin
      wait_q <= '0;
    end else begin
      wait_q       <= wait_q + 8'd1;
      // Length of the latest strobe, held after it drops
      stb_cycles_o <= wait_q + 8'd1;
      // First strobe cycle opens a new access
      if (wait_q == 8'd0) begin
        access_cnt_o <= access_cnt_o + 16'd1;
        last_req_o   <= req_i;
      end
      if (ack_o && req_i.we) begin
        regs_q[req_i.addr[3:0]] <= req_i.wdata;
      end
    end
  end

endmodule

`default_nettype wire

/* testbench/tb_dbg_cpu_bridge.sv */
// Directed table test with one access at a time; the target aliases SPR addresses on bits [3:0]
`timescale 1ns/1ps
`default_nettype none

module tb_dbg_cpu_bridge;
  import dbg_spr_pkg::*;
  import dbg_port_pkg::*;

  // One debug access with its expected outcome
  typedef struct packed {
    logic       rd;
    spr_addr_t  addr;
    spr_data_t  wdata;
    logic [7:0] delay;
    logic       exp_err;
    // Strobe again while the access is in flight
    logic       restrobe;
  } entry_t;

  localparam int unsigned NUM_TABLE   = 17;
  // Table plus register fill and final read sweep
  localparam int unsigned NUM_ACCESS  = NUM_TABLE + 32;
  localparam int unsigned CYCLE_LIMIT =
    NUM_ACCESS * (SPR_TIMEOUT_CYCLES + 8 * SYNC_STAGES + 255) * 2;
  localparam logic [7:0]  NO_ACK      = 8'hff;

  logic        cpu_clk_i;
  logic        tck_i;
  logic        rst_i;
  logic        strobe_i;
  logic        rd_wrn_i;
  spr_addr_t   addr_i;
  spr_data_t   data_i;
  logic        rdy_o;
  dbg_rsp_t    rsp_o;
  spr_req_t    cpu_req_o;
  logic        cpu_stb_o;
  logic        cpu_ack_i;
  spr_data_t   cpu_data_i;
  // Target model side
  logic [7:0]  ack_delay;
  logic [15:0] access_cnt;
  spr_req_t    last_req;
  logic [7:0]  stb_cycles;
  // Scoreboard state
  entry_t      table_q [NUM_TABLE];
  spr_data_t   ref_mem [16];
  spr_data_t   last_rdata;
  logic [31:0] lfsr_q;
  int unsigned cycle_cnt = 0;

  dbg_cpu_bridge dut0 (
    .tck_i      (tck_i),
    .cpu_clk_i  (cpu_clk_i),
    .rst_i      (rst_i),
    .strobe_i   (strobe_i),
    .rd_wrn_i   (rd_wrn_i),
    .addr_i     (addr_i),
    .data_i     (data_i),
    .rdy_o      (rdy_o),
    .rsp_o      (rsp_o),
    .cpu_req_o  (cpu_req_o),
    .cpu_stb_o  (cpu_stb_o),
    .cpu_ack_i  (cpu_ack_i),
    .cpu_data_i (cpu_data_i)
  );

  spr_target_model target0 (
    .cpu_clk_i    (cpu_clk_i),
    .rst_i        (rst_i),
    .req_i        (cpu_req_o),
    .stb_i        (cpu_stb_o),
    .ack_delay_i  (ack_delay),
    .ack_o        (cpu_ack_i),
    .data_o       (cpu_data_i),
    .access_cnt_o (access_cnt),
    .last_req_o   (last_req),
    .stb_cycles_o (stb_cycles)
  );

  ////////////////////////////////////////
  // Clocks and run limit
  ////////////////////////////////////////

  initial begin
    cpu_clk_i = 1'b0;
    forever #2 cpu_clk_i = ~cpu_clk_i;
  end

  // Offset keeps TCK falling edges off every CPU edge
  initial begin
    tck_i = 1'b0;
    #1;
    forever #5 tck_i = ~tck_i;
  end

  always @(posedge cpu_clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Run hung: no access finished within %0d CPU clock cycles", CYCLE_LIMIT);
      $display("TEST FAILED");
      $fatal(1);
    end
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s, got 0x%08h, expected 0x%08h", $time, what, got, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per data bit
  task automatic draw_word(output spr_data_t w);
    w = '0;
    for (int b = 0; b < 32; b++) begin
      lfsr_q = lfsr_next(lfsr_q);
      w      = {w[30:0], lfsr_q[0]};
    end
  endtask

  task automatic wait_ready();
    @(negedge tck_i);
    while (!rdy_o) begin
      @(negedge tck_i);
    end
  endtask

  task automatic run_access(input entry_t e);
    logic [15:0] cnt_before;
    spr_data_t   exp_rdata;
    logic [7:0]  exp_stb;
    wait_ready();
    cnt_before = access_cnt;
    // Present the request for one TCK cycle
    strobe_i  = 1'b1;
    rd_wrn_i  = e.rd;
    addr_i    = e.addr;
    data_i    = e.wdata;
    ack_delay = e.delay;
    @(negedge tck_i);
    strobe_i = 1'b0;
    check(32'(rdy_o), 32'd0, "ready still high after accept");
    if (e.restrobe) begin
      @(negedge tck_i);
      check(32'(rdy_o), 32'd0, "access ended before the second strobe");
      // A different request that must be dropped
      strobe_i = 1'b1;
      rd_wrn_i = !e.rd;
      addr_i   = e.addr ^ 32'h1;
      data_i   = ~e.wdata;
      @(negedge tck_i);
      strobe_i = 1'b0;
    end
    wait_ready();
    // Expected response from the bridge rules
    if (e.exp_err) begin
      exp_rdata = '0;
      exp_stb   = 8'(SPR_TIMEOUT_CYCLES);
    end else begin
      exp_stb = e.delay + 8'd1;
      if (e.rd) begin
        exp_rdata = ref_mem[e.addr[3:0]];
      end else begin
        // Writes show the previous read data
        exp_rdata = last_rdata;
        ref_mem[e.addr[3:0]] = e.wdata;
      end
    end
    last_rdata = exp_rdata;
    check(32'(rsp_o.err), 32'(e.exp_err), "response error flag");
    check(rsp_o.rdata, exp_rdata, "response read data");
    check(32'(access_cnt), 32'(cnt_before) + 32'd1, "accesses seen by target");
    check(last_req.addr, e.addr, "target request address");
    check(32'(last_req.we), 32'(!e.rd), "target write flag");
    if (!e.rd) begin
      check(last_req.wdata, e.wdata, "target write data");
    end
    check(32'(stb_cycles), 32'(exp_stb), "strobe length in CPU cycles");
    check(32'(cpu_stb_o), 32'd0, "strobe still high with ready");
  endtask

  task automatic load_table();
    // Single-cycle writes then reads
    table_q[0]  = '{1'b0, 32'h0000_0003, 32'h1111_0003, 8'd0, 1'b0, 1'b0};
    table_q[1]  = '{1'b0, 32'h0000_0007, 32'h2222_0007, 8'd0, 1'b0, 1'b0};
    table_q[2]  = '{1'b1, 32'h0000_0003, 32'h0, 8'd0, 1'b0, 1'b0};
    table_q[3]  = '{1'b1, 32'h0000_0007, 32'h0, 8'd0, 1'b0, 1'b0};
    // Multi-cycle acknowledges, 0x1c aliases register 12
    table_q[4]  = '{1'b0, 32'h0000_0003, 32'h3333_0003, 8'd3, 1'b0, 1'b0};
    table_q[5]  = '{1'b1, 32'h0000_0003, 32'h0, 8'd5, 1'b0, 1'b0};
    table_q[6]  = '{1'b1, 32'h0000_0007, 32'h0, 8'd1, 1'b0, 1'b0};
    table_q[7]  = '{1'b0, 32'h0000_001c, 32'h4444_000c, 8'd2, 1'b0, 1'b0};
    table_q[8]  = '{1'b1, 32'h0000_001c, 32'h0, 8'd7, 1'b0, 1'b0};
    // Hung accesses and recovery
    table_q[9]  = '{1'b1, 32'h0000_0005, 32'h0, NO_ACK, 1'b1, 1'b0};
    table_q[10] = '{1'b1, 32'h0000_0005, 32'h0, 8'd0, 1'b0, 1'b0};
    table_q[11] = '{1'b0, 32'h0000_0009, 32'h5555_0009, NO_ACK, 1'b1, 1'b0};
    table_q[12] = '{1'b1, 32'h0000_0009, 32'h0, 8'd2, 1'b0, 1'b0};
    // Strobes under back-pressure
    table_q[13] = '{1'b0, 32'h0000_000a, 32'h6666_000a, 8'd10, 1'b0, 1'b1};
    table_q[14] = '{1'b1, 32'h0000_000a, 32'h0, 8'd4, 1'b0, 1'b1};
    // Ack in the expiry cycle, then one cycle too late
    table_q[15] = '{1'b1, 32'h0000_000c, 32'h0, 8'd15, 1'b0, 1'b0};
    table_q[16] = '{1'b0, 32'h0000_000e, 32'h7777_000e, 8'd16, 1'b1, 1'b0};
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    entry_t    e;
    spr_data_t w;
    rst_i      = 1'b1;
    strobe_i   = 1'b0;
    rd_wrn_i   = 1'b1;
    addr_i     = '0;
    data_i     = '0;
    ack_delay  = 8'd0;
    lfsr_q     = 32'hb4f5;
    last_rdata = '0;
    load_table();
    repeat (5) @(posedge cpu_clk_i);
    @(negedge tck_i);
    rst_i = 1'b0;
    // Idle state straight after reset
    @(negedge tck_i);
    check(32'(rdy_o), 32'd1, "ready after reset");
    check(32'(cpu_stb_o), 32'd0, "strobe after reset");
    check(rsp_o.rdata, 32'h0, "read data after reset");
    check(32'(rsp_o.err), 32'd0, "error flag after reset");
    // Random contents in every register
    for (int i = 0; i < 16; i++) begin
      draw_word(w);
      e = '{1'b0, 32'(i), w, 8'd0, 1'b0, 1'b0};
      run_access(e);
    end
    for (int i = 0; i < NUM_TABLE; i++) begin
      run_access(table_q[i]);
    end
    // Sweep catches writes that hit the wrong register
    for (int i = 0; i < 16; i++) begin
      e = '{1'b1, 32'(i), 32'h0, 8'(i % 3), 1'b0, 1'b0};
      run_access(e);
    end
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire
